// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f sim.f --top-module tb_id_decode -o tb_sim
	./obj_dir/tb_sim 2>&1 | tee sim.log
	@if grep -qF '** FAIL **' sim.log || ! grep -qF '** PASS **' sim.log; then \
		echo "test failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== rtl/ctrl_pkg.sv ====
package ctrl_pkg;

    // ------------------------------------------------------------------
    // ex stage alu operation
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,   // result unused
        ALU_ADD = 4'd1,   // also address calc for ld/st
        ALU_SUB = 4'd2,
        ALU_SLL = 4'd3,
        ALU_SRL = 4'd4,
        ALU_SRA = 4'd5,
        ALU_XOR = 4'd6,
        ALU_OR  = 4'd7,
        ALU_AND = 4'd8
    } alu_op_e;

    // ------------------------------------------------------------------
    // mem stage access
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        MEM_NOP = 4'd0,
        MEM_LB  = 4'd1,
        MEM_LH  = 4'd2,
        MEM_LW  = 4'd3,
        MEM_LBU = 4'd4,
        MEM_LHU = 4'd5,
        MEM_SB  = 4'd6,   // stores from here up
        MEM_SH  = 4'd7,
        MEM_SW  = 4'd8
    } mem_op_e;

    // which ex unit feeds write-back
    typedef enum logic {
        EX_OUT_ALU = 1'b0,
        EX_OUT_CMP = 1'b1   // slt/sltu result
    } ex_out_sel_e;

    // bit 0 rs1 read, bit 1 rs2 read; used by hazard logic downstream
    typedef logic [1:0] src_used_t;

endpackage

// ==== rtl/id_decode.sv ====
`timescale 1ns/100ps

module id_decode (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  isa_pkg::word_t        if_insn_i,   // from IF/ID reg
    input  logic                  if_en_i,
    input  isa_pkg::word_t        ra_data_i,   // gpr read data, same cycle
    input  isa_pkg::word_t        rb_data_i,
    output isa_pkg::reg_addr_t    gpr_rd_addr_0_o,
    output isa_pkg::reg_addr_t    gpr_rd_addr_1_o,
    output logic                  ex_en_o,
    output ctrl_pkg::alu_op_e     ex_alu_op_o,
    output isa_pkg::word_t        ex_alu_in_0_o,
    output isa_pkg::word_t        ex_alu_in_1_o,
    output ctrl_pkg::mem_op_e     ex_mem_op_o,
    output isa_pkg::word_t        ex_mem_wr_data_o,
    output ctrl_pkg::ex_out_sel_e ex_out_sel_o,
    output logic                  ex_gpr_we_o,
    output isa_pkg::reg_addr_t    ex_dst_addr_o,
    output ctrl_pkg::src_used_t   ex_src_used_o,
    output logic                  ex_illegal_o
);

    // ------------------------------------------------------------------
    // fields and immediates
    // ------------------------------------------------------------------
    isa_pkg::reg_addr_t rd_addr;
    isa_pkg::opcode_t   opcode;
    isa_pkg::funct3_t   funct3;
    isa_pkg::funct7_t   funct7;
    isa_pkg::word_t     imm_i;
    isa_pkg::word_t     imm_ir;
    isa_pkg::word_t     imm_s;

    // unregistered decode results
    ctrl_pkg::alu_op_e     alu_op;
    isa_pkg::word_t        alu_in_0;
    isa_pkg::word_t        alu_in_1;
    ctrl_pkg::mem_op_e     mem_op;
    ctrl_pkg::ex_out_sel_e ex_out_sel;
    logic                  gpr_we;
    ctrl_pkg::src_used_t   src_used;
    logic                  illegal;

    imm_gen u_imm_gen (
        .insn_i     (if_insn_i),
        .rs1_addr_o (gpr_rd_addr_0_o),   // straight to the gpr file
        .rs2_addr_o (gpr_rd_addr_1_o),
        .rd_addr_o  (rd_addr),
        .opcode_o   (opcode),
        .funct3_o   (funct3),
        .funct7_o   (funct7),
        .imm_i_o    (imm_i),
        .imm_ir_o   (imm_ir),
        .imm_s_o    (imm_s)
    );

    op_decoder u_op_decoder (
        .en_i         (if_en_i),
        .opcode_i     (opcode),
        .funct3_i     (funct3),
        .funct7_i     (funct7),
        .imm_i_i      (imm_i),
        .imm_ir_i     (imm_ir),
        .imm_s_i      (imm_s),
        .ra_data_i    (ra_data_i),
        .rb_data_i    (rb_data_i),
        .alu_op_o     (alu_op),
        .alu_in_0_o   (alu_in_0),
        .alu_in_1_o   (alu_in_1),
        .mem_op_o     (mem_op),
        .ex_out_sel_o (ex_out_sel),
        .gpr_we_o     (gpr_we),
        .src_used_o   (src_used),
        .illegal_o    (illegal)
    );

    // ------------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------------
    id_ex_reg u_id_ex_reg (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .en_i             (if_en_i),
        .alu_op_i         (alu_op),
        .alu_in_0_i       (alu_in_0),
        .alu_in_1_i       (alu_in_1),
        .mem_op_i         (mem_op),
        .ex_out_sel_i     (ex_out_sel),
        .gpr_we_i         (gpr_we),
        .src_used_i       (src_used),
        .illegal_i        (illegal),
        .rb_data_i        (rb_data_i),
        .rd_addr_i        (rd_addr),
        .ex_en_o          (ex_en_o),
        .ex_alu_op_o      (ex_alu_op_o),
        .ex_alu_in_0_o    (ex_alu_in_0_o),
        .ex_alu_in_1_o    (ex_alu_in_1_o),
        .ex_mem_op_o      (ex_mem_op_o),
        .ex_mem_wr_data_o (ex_mem_wr_data_o),
        .ex_out_sel_o     (ex_out_sel_o),
        .ex_gpr_we_o      (ex_gpr_we_o),
        .ex_dst_addr_o    (ex_dst_addr_o),
        .ex_src_used_o    (ex_src_used_o),
        .ex_illegal_o     (ex_illegal_o)
    );

endmodule

// ==== rtl/id_ex_reg.sv ====
`timescale 1ns/100ps

module id_ex_reg (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  en_i,
    input  ctrl_pkg::alu_op_e     alu_op_i,
    input  isa_pkg::word_t        alu_in_0_i,
    input  isa_pkg::word_t        alu_in_1_i,
    input  ctrl_pkg::mem_op_e     mem_op_i,
    input  ctrl_pkg::ex_out_sel_e ex_out_sel_i,
    input  logic                  gpr_we_i,
    input  ctrl_pkg::src_used_t   src_used_i,
    input  logic                  illegal_i,
    input  isa_pkg::word_t        rb_data_i,
    input  isa_pkg::reg_addr_t    rd_addr_i,
    output logic                  ex_en_o,
    output ctrl_pkg::alu_op_e     ex_alu_op_o,
    output isa_pkg::word_t        ex_alu_in_0_o,
    output isa_pkg::word_t        ex_alu_in_1_o,
    output ctrl_pkg::mem_op_e     ex_mem_op_o,
    output isa_pkg::word_t        ex_mem_wr_data_o,
    output ctrl_pkg::ex_out_sel_e ex_out_sel_o,
    output logic                  ex_gpr_we_o,
    output isa_pkg::reg_addr_t    ex_dst_addr_o,
    output ctrl_pkg::src_used_t   ex_src_used_o,
    output logic                  ex_illegal_o
);

    // ------------------------------------------------------------------
    // control half, cleared on reset
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_en_o       <= 1'b0;
            ex_alu_op_o   <= ctrl_pkg::ALU_NOP;
            ex_mem_op_o   <= ctrl_pkg::MEM_NOP;
            ex_out_sel_o  <= ctrl_pkg::EX_OUT_ALU;
            ex_gpr_we_o   <= 1'b0;
            ex_src_used_o <= 2'b00;
            ex_illegal_o  <= 1'b0;
        end else begin
            // no stall, a new slot every edge
            ex_en_o       <= en_i;
            ex_alu_op_o   <= alu_op_i;
            ex_mem_op_o   <= mem_op_i;
            ex_out_sel_o  <= ex_out_sel_i;
            ex_gpr_we_o   <= gpr_we_i;       // already low for bubbles
            ex_src_used_o <= src_used_i;
            ex_illegal_o  <= illegal_i;
        end
    end

    // ------------------------------------------------------------------
    // operand half
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_alu_in_0_o    <= '0;
            ex_alu_in_1_o    <= '0;
            ex_mem_wr_data_o <= '0;
            ex_dst_addr_o    <= '0;
        end else begin
            ex_alu_in_0_o    <= alu_in_0_i;
            ex_alu_in_1_o    <= alu_in_1_i;
            ex_mem_wr_data_o <= rb_data_i;       // rs2 value for stores
            ex_dst_addr_o    <= rd_addr_i;
        end
    end

endmodule

// ==== rtl/imm_gen.sv ====
`timescale 1ns/100ps

module imm_gen (
    input  isa_pkg::word_t     insn_i,
    output isa_pkg::reg_addr_t rs1_addr_o,
    output isa_pkg::reg_addr_t rs2_addr_o,
    output isa_pkg::reg_addr_t rd_addr_o,
    output isa_pkg::opcode_t   opcode_o,
    output isa_pkg::funct3_t   funct3_o,
    output isa_pkg::funct7_t   funct7_o,
    output isa_pkg::word_t     imm_i_o,
    output isa_pkg::word_t     imm_ir_o,
    output isa_pkg::word_t     imm_s_o
);

    // ------------------------------------------------------------------
    // field slicing
    // ------------------------------------------------------------------
    assign opcode_o   = insn_i[0 +: $bits(isa_pkg::opcode_t)];
    assign rd_addr_o  = insn_i[isa_pkg::RD_LSB +: $bits(isa_pkg::reg_addr_t)];
    assign funct3_o   = insn_i[isa_pkg::FUNCT3_LSB +: $bits(isa_pkg::funct3_t)];
    assign rs1_addr_o = insn_i[isa_pkg::RS1_LSB +: $bits(isa_pkg::reg_addr_t)];
    assign rs2_addr_o = insn_i[isa_pkg::RS2_LSB +: $bits(isa_pkg::reg_addr_t)];
    assign funct7_o   = insn_i[isa_pkg::FUNCT7_LSB +: $bits(isa_pkg::funct7_t)];

    // ------------------------------------------------------------------
    // immediates
    // ------------------------------------------------------------------
    // I-type, loads and alu-imm
    assign imm_i_o  = {{20{insn_i[31]}}, insn_i[31:20]};

    // shift amount sits in the rs2 slot, zero extended
    assign imm_ir_o = {27'd0, insn_i[isa_pkg::RS2_LSB +: 5]};

    // S-type offset split around rd slot
    assign imm_s_o  = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};

endmodule

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    // ------------------------------------------------------------------
    // word and field types
    // ------------------------------------------------------------------
    typedef logic [31:0] word_t;      // data / insn word
    typedef logic [4:0]  reg_addr_t;  // gpr index
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // lsb position of each field in the insn word
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;   // also shamt in I-type shifts
    localparam int FUNCT7_LSB = 25;

    // ------------------------------------------------------------------
    // major opcodes
    // ------------------------------------------------------------------
    localparam opcode_t OP_NOP     = 7'b0000000;  // all-zero bubble word
    localparam opcode_t OP_LOAD    = 7'b0000011;
    localparam opcode_t OP_ALU_IMM = 7'b0010011;
    localparam opcode_t OP_STORE   = 7'b0100011;
    localparam opcode_t OP_ALU_REG = 7'b0110011;

    // load widths
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // store widths
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    // alu ops, shared by imm and reg forms
    localparam funct3_t F3_ADD  = 3'b000;  // ADD/SUB, ADDI
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // SRL/SRA split by funct7
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

endpackage

// ==== rtl/op_decoder.sv ====
`timescale 1ns/100ps

module op_decoder (
    input  logic                  en_i,
    input  isa_pkg::opcode_t      opcode_i,
    input  isa_pkg::funct3_t      funct3_i,
    input  isa_pkg::funct7_t      funct7_i,
    input  isa_pkg::word_t        imm_i_i,
    input  isa_pkg::word_t        imm_ir_i,
    input  isa_pkg::word_t        imm_s_i,
    input  isa_pkg::word_t        ra_data_i,
    input  isa_pkg::word_t        rb_data_i,
    output ctrl_pkg::alu_op_e     alu_op_o,
    output isa_pkg::word_t        alu_in_0_o,
    output isa_pkg::word_t        alu_in_1_o,
    output ctrl_pkg::mem_op_e     mem_op_o,
    output ctrl_pkg::ex_out_sel_e ex_out_sel_o,
    output logic                  gpr_we_o,
    output ctrl_pkg::src_used_t   src_used_o,
    output logic                  illegal_o
);

    always_comb begin
        // defaults, also what a bubble or bad insn leaves behind
        alu_op_o     = ctrl_pkg::ALU_NOP;
        alu_in_0_o   = ra_data_i;
        alu_in_1_o   = rb_data_i;
        mem_op_o     = ctrl_pkg::MEM_NOP;
        ex_out_sel_o = ctrl_pkg::EX_OUT_ALU;
        gpr_we_o     = 1'b0;
        src_used_o   = 2'b00;
        illegal_o    = 1'b0;

        if (en_i) begin
            case (opcode_i)
                isa_pkg::OP_NOP: begin
                    // bubble, nothing to do
                end

                // ----------------------------------------------------------
                // loads: rs1 + imm_i
                // ----------------------------------------------------------
                isa_pkg::OP_LOAD: begin
                    alu_op_o   = ctrl_pkg::ALU_ADD;   // address calc
                    alu_in_1_o = imm_i_i;
                    gpr_we_o   = 1'b1;
                    src_used_o = 2'b01;               // rs1 only
                    case (funct3_i)
                        isa_pkg::F3_LB:  mem_op_o = ctrl_pkg::MEM_LB;
                        isa_pkg::F3_LH:  mem_op_o = ctrl_pkg::MEM_LH;
                        isa_pkg::F3_LW:  mem_op_o = ctrl_pkg::MEM_LW;
                        isa_pkg::F3_LBU: mem_op_o = ctrl_pkg::MEM_LBU;
                        isa_pkg::F3_LHU: mem_op_o = ctrl_pkg::MEM_LHU;
                        default:         illegal_o = 1'b1;
                    endcase
                end

                // ----------------------------------------------------------
                // alu with immediate, src flags stay 00 for this class
                // ----------------------------------------------------------
                isa_pkg::OP_ALU_IMM: begin
                    alu_in_1_o = imm_i_i;
                    gpr_we_o   = 1'b1;
                    case (funct3_i)
                        isa_pkg::F3_ADD:  alu_op_o = ctrl_pkg::ALU_ADD;
                        isa_pkg::F3_SLL: begin
                            alu_op_o  = ctrl_pkg::ALU_SLL;  // imm_i == shamt here
                            illegal_o = (funct7_i != isa_pkg::F7_BASE);
                        end
                        isa_pkg::F3_SLT,
                        isa_pkg::F3_SLTU: ex_out_sel_o = ctrl_pkg::EX_OUT_CMP; // alu idle
                        isa_pkg::F3_XOR:  alu_op_o = ctrl_pkg::ALU_XOR;
                        isa_pkg::F3_SR: begin
                            alu_in_1_o = imm_ir_i;          // plain 5 bit shamt
                            if (funct7_i == isa_pkg::F7_BASE) begin
                                alu_op_o = ctrl_pkg::ALU_SRL;
                            end else if (funct7_i == isa_pkg::F7_ALT) begin
                                alu_op_o = ctrl_pkg::ALU_SRA;
                            end else begin
                                illegal_o = 1'b1;
                            end
                        end
                        isa_pkg::F3_OR:   alu_op_o = ctrl_pkg::ALU_OR;
                        isa_pkg::F3_AND:  alu_op_o = ctrl_pkg::ALU_AND;
                        default:          illegal_o = 1'b1;
                    endcase
                end

                // ----------------------------------------------------------
                // register-register
                // ----------------------------------------------------------
                isa_pkg::OP_ALU_REG: begin
                    gpr_we_o   = 1'b1;
                    src_used_o = 2'b11;
                    case (funct3_i)
                        isa_pkg::F3_ADD: begin
                            if (funct7_i == isa_pkg::F7_BASE) begin
                                alu_op_o = ctrl_pkg::ALU_ADD;
                            end else if (funct7_i == isa_pkg::F7_ALT) begin
                                alu_op_o = ctrl_pkg::ALU_SUB;
                            end else begin
                                illegal_o = 1'b1;
                            end
                        end
                        isa_pkg::F3_SLL:  alu_op_o = ctrl_pkg::ALU_SLL;
                        isa_pkg::F3_SLT,
                        isa_pkg::F3_SLTU: ex_out_sel_o = ctrl_pkg::EX_OUT_CMP;
                        isa_pkg::F3_XOR:  alu_op_o = ctrl_pkg::ALU_XOR;
                        isa_pkg::F3_SR: begin
                            if (funct7_i == isa_pkg::F7_BASE) begin
                                alu_op_o = ctrl_pkg::ALU_SRL;
                            end else if (funct7_i == isa_pkg::F7_ALT) begin
                                alu_op_o = ctrl_pkg::ALU_SRA;
                            end else begin
                                illegal_o = 1'b1;
                            end
                        end
                        isa_pkg::F3_OR:   alu_op_o = ctrl_pkg::ALU_OR;
                        isa_pkg::F3_AND:  alu_op_o = ctrl_pkg::ALU_AND;
                        default:          illegal_o = 1'b1;
                    endcase
                    // only ADD/SUB and SRL/SRA have an alternate funct7
                    if (funct3_i != isa_pkg::F3_ADD && funct3_i != isa_pkg::F3_SR &&
                        funct7_i != isa_pkg::F7_BASE) begin
                        illegal_o = 1'b1;
                    end
                end

                // ----------------------------------------------------------
                // stores: rs1 + imm_s, data comes from rs2
                // ----------------------------------------------------------
                isa_pkg::OP_STORE: begin
                    alu_op_o   = ctrl_pkg::ALU_ADD;
                    alu_in_1_o = imm_s_i;
                    src_used_o = 2'b11;
                    case (funct3_i)
                        isa_pkg::F3_SB: mem_op_o = ctrl_pkg::MEM_SB;
                        isa_pkg::F3_SH: mem_op_o = ctrl_pkg::MEM_SH;
                        isa_pkg::F3_SW: mem_op_o = ctrl_pkg::MEM_SW;
                        default:        illegal_o = 1'b1;
                    endcase
                end

                default: illegal_o = 1'b1;   // unknown opcode
            endcase

            // bad encoding, drop back to the inert defaults
            if (illegal_o) begin
                alu_op_o     = ctrl_pkg::ALU_NOP;
                alu_in_1_o   = rb_data_i;
                mem_op_o     = ctrl_pkg::MEM_NOP;
                ex_out_sel_o = ctrl_pkg::EX_OUT_ALU;
                gpr_we_o     = 1'b0;
                src_used_o   = 2'b00;
            end
        end
    end

endmodule

// ==== sim.f ====
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/imm_gen.sv
rtl/op_decoder.sv
rtl/id_ex_reg.sv
rtl/id_decode.sv
tb/id_decode_chk.sv
tb/tb_id_decode.sv

// ==== tb/id_decode_chk.sv ====
`timescale 1ns/100ps

module id_decode_chk (
    input logic              clk_i,
    input logic              rst_n_i,
    input logic              ex_en_i,
    input logic              ex_gpr_we_i,
    input logic              ex_illegal_i,
    input ctrl_pkg::mem_op_e ex_mem_op_i
);

    // bad encoding never reaches write-back
    illegal_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ex_illegal_i |-> !ex_gpr_we_i)
        else $error("illegal slot carries a register write");

    bubble_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !ex_en_i |-> !ex_gpr_we_i)
        else $error("disabled slot carries a register write");

    // SB and up are stores
    store_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ex_mem_op_i >= ctrl_pkg::MEM_SB) |-> !ex_gpr_we_i)
        else $error("store carries a register write");

endmodule

bind id_decode id_decode_chk u_chk (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ex_en_i      (ex_en_o),
    .ex_gpr_we_i  (ex_gpr_we_o),
    .ex_illegal_i (ex_illegal_o),
    .ex_mem_op_i  (ex_mem_op_o)
);

// ==== tb/id_decode_testdata.txt ====
// insn ra rb en | expected: alu_op alu_in_0 alu_in_1 mem_op mem_wr_data out_sel gpr_we rd src ill
// alu_op 0 NOP 1 ADD 2 SUB 3 SLL 4 SRL 5 SRA 6 XOR 7 OR 8 AND; mem_op 1..5 loads, 6..8 SB SH SW
0080A103 00001000 0000BEEF 1 1 00001000 00000008 3 0000BEEF 0 1 02 1 0
FFC28183 00002000 12345678 1 1 00002000 FFFFFFFC 1 12345678 0 1 03 1 0
0020A623 0000AAAA 0000BBBB 0 0 0000AAAA 0000BBBB 0 0000BBBB 0 0 0C 0 0
FFE0D403 00000100 00000000 1 1 00000100 FFFFFFFE 5 00000000 0 1 08 1 0
0020A623 00004000 CAFEF00D 1 1 00004000 0000000C 8 CAFEF00D 0 0 0C 3 0
FE328FA3 00000010 000000AB 1 1 00000010 FFFFFFFF 6 000000AB 0 0 1F 3 0
02431023 00000200 0000BBCC 1 1 00000200 00000020 7 0000BBCC 0 0 00 3 0
FFF08113 00000005 00000007 1 1 00000005 FFFFFFFF 0 00000007 0 1 02 0 0
00509193 80000001 00000009 1 3 80000001 00000005 0 00000009 0 1 03 0 0
0010B293 00000000 00000011 1 0 00000000 00000001 0 00000011 1 1 05 0 0
41F0D413 F0000000 00000013 1 5 F0000000 0000001F 0 00000013 0 1 08 0 0
0F00F513 0000FFFF 00000015 1 8 0000FFFF 000000F0 0 00000015 0 1 0A 0 0
402081B3 00000064 00000032 1 2 00000064 00000032 0 00000032 0 1 03 3 0
0020A1B3 FFFFFFFF 00000001 1 0 FFFFFFFF 00000001 0 00000001 1 1 03 3 0
4020D1B3 80000000 00000004 1 5 80000000 00000004 0 00000004 0 1 03 3 0
0020F1B3 0F0F0F0F 00FF00FF 1 8 0F0F0F0F 00FF00FF 0 00FF00FF 0 1 03 3 0
002081B3 00000001 00000002 0 0 00000001 00000002 0 00000002 0 0 03 0 0
002081FF 00000003 00000004 1 0 00000003 00000004 0 00000004 0 0 03 0 1
0000B103 00000005 00000006 1 0 00000005 00000006 0 00000006 0 0 02 0 1
2030D393 00000007 00000008 1 0 00000007 00000008 0 00000008 0 0 07 0 1
022081B3 00000009 0000000A 1 0 00000009 0000000A 0 0000000A 0 0 03 0 1
00000000 0000000B 0000000C 1 0 0000000B 0000000C 0 0000000C 0 0 00 0 0

// ==== tb/tb_id_decode.sv ====
`timescale 1ns/100ps

module tb_id_decode;

    localparam int COLS    = 14;   // words per vector line
    localparam int MAX_VEC = 64;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  if_en_i;
    isa_pkg::word_t        if_insn_i, ra_data_i, rb_data_i;
    isa_pkg::reg_addr_t    gpr_rd_addr_0_o, gpr_rd_addr_1_o, ex_dst_addr_o;
    logic                  ex_en_o, ex_gpr_we_o, ex_illegal_o;
    ctrl_pkg::alu_op_e     ex_alu_op_o;
    ctrl_pkg::mem_op_e     ex_mem_op_o;
    ctrl_pkg::ex_out_sel_e ex_out_sel_o;
    isa_pkg::word_t        ex_alu_in_0_o, ex_alu_in_1_o, ex_mem_wr_data_o;
    ctrl_pkg::src_used_t   ex_src_used_o;

    logic [31:0] vec_mem [COLS*MAX_VEC];   // flat, COLS words per vector
    int n_vec  = 0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    id_decode UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;   // 20 ns period
    end

    // watchdog, reset plus one edge per vector plus margin
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > n_vec + 20) begin
            $display("timeout: run stuck after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // ------------------------------------------------------------------
    // vector handling
    // ------------------------------------------------------------------
    task apply_vector(input int v);
        if_insn_i = vec_mem[v*COLS];
        ra_data_i = vec_mem[v*COLS+1];
        rb_data_i = vec_mem[v*COLS+2];
        if_en_i   = vec_mem[v*COLS+3][0];
    endtask

    task check_vector(input int v);
        int b;
        b = v * COLS;
        check_field("ex_en_o",          vec_mem[b+3],  32'(ex_en_o));
        check_field("ex_alu_op_o",      vec_mem[b+4],  32'(ex_alu_op_o));
        check_field("ex_alu_in_0_o",    vec_mem[b+5],  ex_alu_in_0_o);
        check_field("ex_alu_in_1_o",    vec_mem[b+6],  ex_alu_in_1_o);
        check_field("ex_mem_op_o",      vec_mem[b+7],  32'(ex_mem_op_o));
        check_field("ex_mem_wr_data_o", vec_mem[b+8],  ex_mem_wr_data_o);
        check_field("ex_out_sel_o",     vec_mem[b+9],  32'(ex_out_sel_o));
        check_field("ex_gpr_we_o",      vec_mem[b+10], 32'(ex_gpr_we_o));
        check_field("ex_dst_addr_o",    vec_mem[b+11], 32'(ex_dst_addr_o));
        check_field("ex_src_used_o",    vec_mem[b+12], 32'(ex_src_used_o));
        check_field("ex_illegal_o",     vec_mem[b+13], 32'(ex_illegal_o));
    endtask

    initial begin
        // enabled LW on the inputs for the whole reset
        if_insn_i = 32'h0080_A103;
        ra_data_i = '0;
        rb_data_i = '0;
        if_en_i   = 1'b1;
        rst_n_i   = 1'b0;
        for (int a = 0; a < COLS*MAX_VEC; a++)
            vec_mem[a] = ~a;   // enable column never reads 0/1 past the end
        $readmemh("tb/id_decode_testdata.txt", vec_mem);
        while (n_vec < MAX_VEC && vec_mem[n_vec*COLS+3] <= 1)
            n_vec++;
        if (n_vec == 0) begin
            $display("no test vectors read from the data file");
            errors++;
        end

        repeat (3) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        // load above never captured, reset values still on the outputs
        check_field("ex_en_o",      32'd0, 32'(ex_en_o));
        check_field("ex_gpr_we_o",  32'd0, 32'(ex_gpr_we_o));
        check_field("ex_illegal_o", 32'd0, 32'(ex_illegal_o));
        check_field("ex_alu_op_o",  32'(ctrl_pkg::ALU_NOP), 32'(ex_alu_op_o));
        check_field("ex_mem_op_o",  32'(ctrl_pkg::MEM_NOP), 32'(ex_mem_op_o));

        // back to back, one vector per edge
        for (int i = 0; i < n_vec; i++) begin
            apply_vector(i);
            #1;
            check_field("gpr_rd_addr_0_o", 32'(if_insn_i[19:15]), 32'(gpr_rd_addr_0_o));
            check_field("gpr_rd_addr_1_o", 32'(if_insn_i[24:20]), 32'(gpr_rd_addr_1_o));
            if (i > 0) begin
                check_vector(i - 1);   // previous slot held while new inputs sit
            end
            @(posedge clk_i);
            #2;
        end

        // idle inputs, last slot must still be held
        if_insn_i = '0;
        if_en_i   = 1'b0;
        #1;
        if (n_vec > 0) begin
            check_vector(n_vec - 1);
        end

        $display("vectors %0d, checks %0d, errors %0d", n_vec, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
